// ==== Bender.yml ====
package:
  name: memory_subsystem

sources:
  - include_dirs:
      - src
    files:
      - src/ArbiterTypes.sv
      - src/MemoryTypes.sv
      - src/MissRequestPort.sv
      - src/MemoryAccessArbiter.sv
      - src/MainMemory.sv
      - src/MemorySubsystem.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/MemorySubsystemTb.sv

// ==== memory_subsystem.f ====
+incdir+src
src/ArbiterTypes.sv
src/MemoryTypes.sv
src/MissRequestPort.sv
src/MemoryAccessArbiter.sv
src/MainMemory.sv
src/MemorySubsystem.sv
tests/MemorySubsystemTb.sv

// ==== src/ArbiterTypes.sv ====
// Arbiter type definitions
package ArbiterTypes;

    // arbiter state encoding.
    // bit 2 marks an access in progress, bit 1 selects the instruction cache,
    // and bit 0 marks a write.
    typedef enum logic [2:0] {
        None        = 3'h0,
        DCacheRead  = 3'h4,
        DCacheWrite = 3'h5,
        ICacheRead  = 3'h6,
        ICacheWrite = 3'h7
    } ArbiterState;

    // which miss port an access belongs to.
    typedef enum logic {
        ICache = 1'b0,
        DCache = 1'b1
    } Requester;

endpackage

// ==== src/MainMemory.sv ====
// Fixed latency main memory
`include "Memory_params.svh"

module MainMemory
    import MemoryTypes::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   memoryEnable,
    input  MemoryOp                memoryOp,
    input  logic [`ADDR_WIDTH-1:0] memoryAddr,
    input  logic [`DATA_WIDTH-1:0] memoryWriteValue,
    output logic                   memoryDone,
    output logic [`DATA_WIDTH-1:0] memoryReadValue
);

    // the counter must reach MEM_LATENCY - 1, so one extra code is plenty.
    localparam int countWidth = $clog2(`MEM_LATENCY + 1);
    localparam logic [countWidth-1:0] lastCount = countWidth'(`MEM_LATENCY - 1);

    MemoryState state;
    MemoryState nextState;
    logic [countWidth-1:0] count;

    // word storage, one entry per address.
    logic [`DATA_WIDTH-1:0] storage [`MEM_DEPTH];

    // word read at the end of the busy phase.
    logic [`DATA_WIDTH-1:0] readWord;

    // the last busy cycle, after which the access completes.
    logic busyEnd;

    assign busyEnd = (state == Busy) && (count == lastCount);

    // controller.
    // idle moves to busy when enabled, busy lasts MEM_LATENCY cycles,
    // and done always lasts exactly one cycle before idle again.
    always_comb begin
        case (state)
            Idle: begin
                nextState = memoryEnable ? Busy : Idle;
            end
            Busy: begin
                nextState = busyEnd ? Done : Busy;
            end
            default: begin
                nextState = Idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= Idle;
            count <= '0;
        end else begin
            state <= nextState;
            // count restarts on every entry into busy.
            if (state == Busy) begin
                count <= count + 1'b1;
            end else begin
                count <= '0;
            end
        end
    end

    // storage access.
    // a read samples the array as busy ends, so the word is stable
    // through the done cycle.
    // a write lands on the edge that closes the done cycle.
    always_ff @(posedge clk) begin
        if (busyEnd) begin
            readWord <= storage[memoryAddr];
        end
        if (state == Done && memoryOp == Write) begin
            storage[memoryAddr] <= memoryWriteValue;
        end
    end

    assign memoryDone      = (state == Done);
    assign memoryReadValue = readWord;

endmodule

// ==== src/MemoryAccessArbiter.sv ====
// Fixed priority memory arbiter
`include "Memory_params.svh"

module MemoryAccessArbiter
    import ArbiterTypes::*;
    import MemoryTypes::*;
(
    input  logic                   clk,
    input  logic                   rst,
    // instruction cache miss port.
    input  logic                   icReadReq,
    input  logic                   icWriteReq,
    input  logic [`ADDR_WIDTH-1:0] icAddr,
    input  logic [`DATA_WIDTH-1:0] icWriteValue,
    output logic                   icReadGrant,
    output logic                   icWriteGrant,
    output logic [`DATA_WIDTH-1:0] icReadValue,
    // data cache miss port.
    input  logic                   dcReadReq,
    input  logic                   dcWriteReq,
    input  logic [`ADDR_WIDTH-1:0] dcAddr,
    input  logic [`DATA_WIDTH-1:0] dcWriteValue,
    output logic                   dcReadGrant,
    output logic                   dcWriteGrant,
    output logic [`DATA_WIDTH-1:0] dcReadValue,
    // main memory side.
    output logic                   memoryEnable,
    output MemoryOp                memoryOp,
    output logic [`ADDR_WIDTH-1:0] memoryAddr,
    output logic [`DATA_WIDTH-1:0] memoryWriteValue,
    input  logic                   memoryDone,
    input  logic [`DATA_WIDTH-1:0] memoryReadValue
);

    ArbiterState state;
    ArbiterState nextState;

    // port that owns the current access, decoded from the state.
    Requester current;

    // next state.
    // in None the highest priority request wins, data write first,
    // then data read, instruction write and instruction read.
    // any other state is held until memory reports completion.
    always_comb begin
        if (state == None) begin
            if (dcWriteReq) begin
                nextState = DCacheWrite;
            end else if (dcReadReq) begin
                nextState = DCacheRead;
            end else if (icWriteReq) begin
                nextState = ICacheWrite;
            end else if (icReadReq) begin
                nextState = ICacheRead;
            end else begin
                nextState = None;
            end
        end else begin
            nextState = memoryDone ? None : state;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= None;
        end else begin
            state <= nextState;
        end
    end

    // bit 1 of the state picks the instruction cache, bit 0 picks a write.
    assign current      = state[1] ? ICache : DCache;
    assign memoryEnable = (state != None);
    assign memoryOp     = state[0] ? Write : Read;

    // steer the owner's address and data to memory.
    // while idle the memory inputs are parked at zero.
    always_comb begin
        if (state == None) begin
            memoryAddr       = '0;
            memoryWriteValue = '0;
        end else if (current == DCache) begin
            memoryAddr       = dcAddr;
            memoryWriteValue = dcWriteValue;
        end else begin
            memoryAddr       = icAddr;
            memoryWriteValue = icWriteValue;
        end
    end

    // the read word goes to both ports, and only the grant for the
    // active state rises, in the same cycle as the memory done.
    assign icReadValue  = memoryReadValue;
    assign dcReadValue  = memoryReadValue;
    assign icReadGrant  = (state == ICacheRead) && memoryDone;
    assign icWriteGrant = (state == ICacheWrite) && memoryDone;
    assign dcReadGrant  = (state == DCacheRead) && memoryDone;
    assign dcWriteGrant = (state == DCacheWrite) && memoryDone;

endmodule

// ==== src/MemorySubsystem.sv ====
// Memory subsystem top level
`include "Memory_params.svh"

module MemorySubsystem
    import MemoryTypes::*;
(
    input  logic                   clk,
    input  logic                   rst,
    // instruction cache miss requests.
    input  logic                   icReqValid,
    input  logic                   icIsWrite,
    input  logic [`ADDR_WIDTH-1:0] icAddr,
    input  logic [`DATA_WIDTH-1:0] icWriteData,
    output logic                   icBusy,
    output logic                   icDone,
    output logic [`DATA_WIDTH-1:0] icReadData,
    // data cache miss requests.
    input  logic                   dcReqValid,
    input  logic                   dcIsWrite,
    input  logic [`ADDR_WIDTH-1:0] dcAddr,
    input  logic [`DATA_WIDTH-1:0] dcWriteData,
    output logic                   dcBusy,
    output logic                   dcDone,
    output logic [`DATA_WIDTH-1:0] dcReadData
);

    // instruction port to arbiter.
    logic                   icReadReq;
    logic                   icWriteReq;
    logic [`ADDR_WIDTH-1:0] icReqAddr;
    logic [`DATA_WIDTH-1:0] icReqWriteValue;
    logic                   icReadGrant;
    logic                   icWriteGrant;
    logic [`DATA_WIDTH-1:0] icReadValue;

    // data port to arbiter.
    logic                   dcReadReq;
    logic                   dcWriteReq;
    logic [`ADDR_WIDTH-1:0] dcReqAddr;
    logic [`DATA_WIDTH-1:0] dcReqWriteValue;
    logic                   dcReadGrant;
    logic                   dcWriteGrant;
    logic [`DATA_WIDTH-1:0] dcReadValue;

    // arbiter to main memory.
    logic                   memoryEnable;
    MemoryOp                memoryOp;
    logic [`ADDR_WIDTH-1:0] memoryAddr;
    logic [`DATA_WIDTH-1:0] memoryWriteValue;
    logic                   memoryDone;
    logic [`DATA_WIDTH-1:0] memoryReadValue;

    MissRequestPort icPort (
        .clk, .rst,
        .reqValid(icReqValid), .isWrite(icIsWrite), .addr(icAddr), .writeData(icWriteData),
        .busy(icBusy), .done(icDone), .readData(icReadData),
        .readReq(icReadReq), .writeReq(icWriteReq),
        .reqAddr(icReqAddr), .reqWriteValue(icReqWriteValue),
        .readGrant(icReadGrant), .writeGrant(icWriteGrant), .readValue(icReadValue)
    );

    MissRequestPort dcPort (
        .clk, .rst,
        .reqValid(dcReqValid), .isWrite(dcIsWrite), .addr(dcAddr), .writeData(dcWriteData),
        .busy(dcBusy), .done(dcDone), .readData(dcReadData),
        .readReq(dcReadReq), .writeReq(dcWriteReq),
        .reqAddr(dcReqAddr), .reqWriteValue(dcReqWriteValue),
        .readGrant(dcReadGrant), .writeGrant(dcWriteGrant), .readValue(dcReadValue)
    );

    MemoryAccessArbiter arbiter (
        .clk, .rst,
        .icReadReq, .icWriteReq, .icAddr(icReqAddr), .icWriteValue(icReqWriteValue),
        .icReadGrant, .icWriteGrant, .icReadValue,
        .dcReadReq, .dcWriteReq, .dcAddr(dcReqAddr), .dcWriteValue(dcReqWriteValue),
        .dcReadGrant, .dcWriteGrant, .dcReadValue,
        .memoryEnable, .memoryOp, .memoryAddr, .memoryWriteValue,
        .memoryDone, .memoryReadValue
    );

    MainMemory mainMemory (
        .clk, .rst,
        .memoryEnable, .memoryOp, .memoryAddr, .memoryWriteValue,
        .memoryDone, .memoryReadValue
    );

endmodule

// ==== src/MemoryTypes.sv ====
// Main memory type definitions
package MemoryTypes;

    // operation requested from main memory.
    typedef enum logic {
        Read  = 1'b0,
        Write = 1'b1
    } MemoryOp;

    // main memory controller state.
    // idle waits for an enable, busy counts off the access latency,
    // and done is the single cycle in which the access completes.
    typedef enum logic [1:0] {
        Idle = 2'd0,
        Busy = 2'd1,
        Done = 2'd2
    } MemoryState;

endpackage

// ==== src/Memory_params.svh ====
// Memory subsystem parameters
`ifndef MEMORY_PARAMS_SVH
`define MEMORY_PARAMS_SVH

// width of a word address into main memory.
`define ADDR_WIDTH 10

// width of one data word moved between the caches and memory.
`define DATA_WIDTH 32

// number of words held by the main memory array.
// this should stay equal to 2 ** ADDR_WIDTH so every address hits a word.
`define MEM_DEPTH 1024

// cycles main memory stays busy on each access before its done pulse.
// any value of 1 or more is valid.
`define MEM_LATENCY 3

`endif

// ==== src/MissRequestPort.sv ====
// Cache miss request port
`include "Memory_params.svh"

module MissRequestPort (
    input  logic                   clk,
    input  logic                   rst,
    // request from the cache side.
    input  logic                   reqValid,
    input  logic                   isWrite,
    input  logic [`ADDR_WIDTH-1:0] addr,
    input  logic [`DATA_WIDTH-1:0] writeData,
    output logic                   busy,
    output logic                   done,
    output logic [`DATA_WIDTH-1:0] readData,
    // request toward the arbiter.
    output logic                   readReq,
    output logic                   writeReq,
    output logic [`ADDR_WIDTH-1:0] reqAddr,
    output logic [`DATA_WIDTH-1:0] reqWriteValue,
    input  logic                   readGrant,
    input  logic                   writeGrant,
    input  logic [`DATA_WIDTH-1:0] readValue
);

    // a new request is taken only while no other one is outstanding.
    // anything offered while busy is dropped, so the cache must watch busy.
    logic accept;

    // the arbiter answered the request that this port is presenting.
    logic granted;

    assign accept  = reqValid && !busy;
    assign granted = (readReq && readGrant) || (writeReq && writeGrant);

    // control flags.
    // the request bits rise one edge after acceptance and fall on the edge
    // that ends the grant cycle, which is also where done rises for one cycle.
    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            done     <= 1'b0;
            readReq  <= 1'b0;
            writeReq <= 1'b0;
        end else begin
            done <= 1'b0;
            if (accept) begin
                busy     <= 1'b1;
                readReq  <= !isWrite;
                writeReq <= isWrite;
            end else if (granted) begin
                busy     <= 1'b0;
                done     <= 1'b1;
                readReq  <= 1'b0;
                writeReq <= 1'b0;
            end
        end
    end

    // request payload.
    // address and write data are held steady from acceptance until the grant.
    // the read word is kept until the next read completes.
    always_ff @(posedge clk) begin
        if (accept) begin
            reqAddr       <= addr;
            reqWriteValue <= writeData;
        end
        if (readReq && readGrant) begin
            readData <= readValue;
        end
    end

endmodule

// ==== tests/MemorySubsystemTb.sv ====
// Memory subsystem testbench
`include "Memory_params.svh"

module MemorySubsystemTb
    import ArbiterTypes::*;
    import MemoryTypes::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    // cycles a port may wait for its done pulse before it counts as stuck.
    localparam int portTimeout = 100;
    localparam int drainLimit = 300;
    localparam int trafficLength = 400;
    localparam int trafficLimit = 20000;
    // random traffic stays inside a small window so both ports collide often.
    localparam int trafficAddrBits = 6;

    logic clk;
    logic rst;
    logic icReqValid;
    logic icIsWrite;
    logic [`ADDR_WIDTH-1:0] icAddr;
    logic [`DATA_WIDTH-1:0] icWriteData;
    logic icBusy;
    logic icDone;
    logic [`DATA_WIDTH-1:0] icReadData;
    logic dcReqValid;
    logic dcIsWrite;
    logic [`ADDR_WIDTH-1:0] dcAddr;
    logic [`DATA_WIDTH-1:0] dcWriteData;
    logic dcBusy;
    logic dcDone;
    logic [`DATA_WIDTH-1:0] dcReadData;

    integer seed;
    int checkCount;
    int errorCount;
    int failCount;
    bit aborted;

    // reference memory, filled in completion order.
    logic [`DATA_WIDTH-1:0] model [logic [`ADDR_WIDTH-1:0]];
    logic [`ADDR_WIDTH-1:0] knownAddrs [$];
    Requester doneOrder [$];

    // bookkeeping for the one request each port may have outstanding.
    bit accepting [2];
    bit pending [2];
    MemoryOp pendOp [2];
    logic [`ADDR_WIDTH-1:0] pendAddr [2];
    logic [`DATA_WIDTH-1:0] pendData [2];
    int waitCycles [2];
    int lastLatency [2];
    int acceptCount [2];
    int doneCount [2];

    MemorySubsystem dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic checkData(string testName, logic [`DATA_WIDTH-1:0] expected,
                             logic [`DATA_WIDTH-1:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("[ERROR] %s: expected %h, actual %h", testName, expected, actual);
        end
    endtask

    task automatic checkBit(string testName, logic expected, logic actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("[ERROR] %s: expected %b, actual %b", testName, expected, actual);
        end
    endtask

    task automatic checkRequester(string testName, Requester expected, Requester actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("[ERROR] %s: expected %s, actual %s", testName, expected.name(),
                     actual.name());
        end
    endtask

    // cycle counts such as latency and the number of done pulses.
    task automatic checkCycles(string testName, int expected, int actual);
        checkCount++;
        if (actual != expected) begin
            errorCount++;
            $display("[ERROR] %s: expected %0d, actual %0d", testName, expected, actual);
        end
    endtask

    function automatic logic portBusy(Requester who);
        return (who == DCache) ? dcBusy : icBusy;
    endfunction

    function automatic logic portDone(Requester who);
        return (who == DCache) ? dcDone : icDone;
    endfunction

    function automatic logic [`DATA_WIDTH-1:0] portReadData(Requester who);
        return (who == DCache) ? dcReadData : icReadData;
    endfunction

    function automatic logic [`ADDR_WIDTH-1:0] randomAddr();
        logic [31:0] r;
        r = $random(seed);
        return {{(`ADDR_WIDTH - trafficAddrBits){1'b0}}, r[trafficAddrBits-1:0]};
    endfunction

    // drives the outside request pins of one port directly.
    task automatic drivePort(Requester who, logic valid, logic write,
                             logic [`ADDR_WIDTH-1:0] a, logic [`DATA_WIDTH-1:0] d);
        if (who == DCache) begin
            dcReqValid  = valid;
            dcIsWrite   = write;
            dcAddr      = a;
            dcWriteData = d;
        end else begin
            icReqValid  = valid;
            icIsWrite   = write;
            icAddr      = a;
            icWriteData = d;
        end
    endtask

    // offers a request that the port will take, since its busy is low now.
    task automatic issue(Requester who, MemoryOp op, logic [`ADDR_WIDTH-1:0] a,
                         logic [`DATA_WIDTH-1:0] d);
        pendOp[who]   = op;
        pendAddr[who] = a;
        pendData[who] = d;
        accepting[who] = 1'b1;
        acceptCount[who]++;
        drivePort(who, 1'b1, op == Write, a, d);
    endtask

    // applies a finished access to the model, or checks a read against it.
    task automatic completeAccess(Requester who, string testName);
        pending[who] = 1'b0;
        lastLatency[who] = waitCycles[who];
        doneOrder.push_back(who);
        if (pendOp[who] == Write) begin
            if (!model.exists(pendAddr[who])) begin
                knownAddrs.push_back(pendAddr[who]);
            end
            model[pendAddr[who]] = pendData[who];
        end else begin
            checkData({testName, " read data"}, model[pendAddr[who]], portReadData(who));
        end
    endtask

    task automatic observePort(Requester who, string testName);
        // every done pulse is counted, whether a request was outstanding or not.
        if (portDone(who)) begin
            doneCount[who]++;
        end
        if (accepting[who]) begin
            // the edge just passed was the accepting edge.
            checkBit({testName, " busy after accept"}, 1'b1, portBusy(who));
            accepting[who] = 1'b0;
            pending[who] = 1'b1;
            waitCycles[who] = 0;
        end else if (pending[who]) begin
            waitCycles[who]++;
            if (portDone(who)) begin
                completeAccess(who, testName);
            end else if (waitCycles[who] > portTimeout) begin
                failCount++;
                aborted = 1'b1;
                pending[who] = 1'b0;
                $display("timeout in %s: the %s port never finished its access",
                         testName, who.name());
            end
        end else if (portDone(who)) begin
            failCount++;
            $display("%s: the %s port pulsed done with no request outstanding",
                     testName, who.name());
        end
    endtask

    // one clock, then outputs are looked at where they are stable.
    // request pins fall back to idle unless the caller drives them again.
    task automatic step(string testName);
        @(posedge clk);
        #2;
        for (int p = 0; p < 2; p++) begin
            observePort(Requester'(p), testName);
        end
        drivePort(ICache, 1'b0, 1'b0, '0, '0);
        drivePort(DCache, 1'b0, 1'b0, '0, '0);
    endtask

    task automatic drain(string testName);
        int guard;
        guard = 0;
        while ((pending[0] || pending[1] || accepting[0] || accepting[1]) && !aborted) begin
            step(testName);
            guard++;
            if (guard > drainLimit) begin
                failCount++;
                aborted = 1'b1;
                $display("timeout in %s: the ports never went idle", testName);
            end
        end
    endtask

    task automatic singleAccessTest(Requester who);
        string name;
        logic [`ADDR_WIDTH-1:0] a;
        logic [`DATA_WIDTH-1:0] d;
        name = (who == DCache) ? "single dc" : "single ic";
        a = randomAddr();
        d = $random(seed);
        issue(who, Write, a, d);
        drain(name);
        if (aborted) return;
        checkCycles({name, " write latency"}, `MEM_LATENCY + 3, lastLatency[who]);
        issue(who, Read, a, '0);
        drain(name);
        if (aborted) return;
        checkCycles({name, " read latency"}, `MEM_LATENCY + 3, lastLatency[who]);
        checkData({name, " read back"}, d, portReadData(who));
    endtask

    // the data write must win, so the instruction read sees the new word.
    task automatic priorityTest();
        logic [`ADDR_WIDTH-1:0] a;
        logic [`DATA_WIDTH-1:0] d;
        a = knownAddrs[0];
        d = $random(seed);
        doneOrder.delete();
        issue(ICache, Read, a, '0);
        issue(DCache, Write, a, d);
        drain("priority");
        if (aborted) return;
        checkCycles("priority done count", 2, doneOrder.size());
        if (doneOrder.size() == 2) begin
            checkRequester("priority first done", DCache, doneOrder[0]);
            checkRequester("priority second done", ICache, doneOrder[1]);
        end
        checkData("priority ic read", d, icReadData);
    endtask

    // a second write offered while busy must leave no trace.
    task automatic backPressureTest();
        logic [`ADDR_WIDTH-1:0] a;
        logic [`DATA_WIDTH-1:0] d;
        int donesBefore;
        int guard;
        a = randomAddr();
        d = $random(seed);
        donesBefore = doneCount[DCache];
        guard = 0;
        issue(DCache, Write, a, d);
        while ((pending[DCache] || accepting[DCache]) && !aborted) begin
            step("back-pressure");
            guard++;
            if (guard > drainLimit) begin
                failCount++;
                aborted = 1'b1;
                $display("timeout in back-pressure: the DCache port never finished");
            end else if (pending[DCache] && dcBusy) begin
                drivePort(DCache, 1'b1, 1'b1, a, ~d);
            end
        end
        drain("back-pressure");
        if (aborted) return;
        checkCycles("back-pressure done count", donesBefore + 1, doneCount[DCache]);
        issue(DCache, Read, a, '0);
        drain("back-pressure");
        if (aborted) return;
        checkData("back-pressure read", d, dcReadData);
    endtask

    task automatic issueRandom(Requester who);
        int idx;
        if (knownAddrs.size() == 0 || (($random(seed) & 1) == 1)) begin
            issue(who, Write, randomAddr(), $random(seed));
        end else begin
            idx = $unsigned($random(seed)) % knownAddrs.size();
            issue(who, Read, knownAddrs[idx], '0);
        end
    endtask

    task automatic randomTrafficTest();
        Requester who;
        int issued;
        int guard;
        int gap [2];
        issued = 0;
        guard = 0;
        gap[0] = 0;
        gap[1] = 0;
        while (issued < trafficLength && !aborted) begin
            step("random");
            guard++;
            if (guard > trafficLimit) begin
                failCount++;
                aborted = 1'b1;
                $display("timeout in random: traffic never finished issuing");
            end
            for (int p = 0; p < 2; p++) begin
                who = Requester'(p);
                if (!pending[who] && !accepting[who]) begin
                    if (gap[p] > 0) begin
                        gap[p]--;
                    end else if (issued < trafficLength && !aborted) begin
                        issueRandom(who);
                        issued++;
                        gap[p] = $unsigned($random(seed)) % 4;
                    end
                end else if (pending[who] && portBusy(who) && (($random(seed) & 7) == 0)) begin
                    // junk offered while busy, which the port must drop.
                    drivePort(who, 1'b1, 1'b1, randomAddr(), $random(seed));
                end
            end
        end
        drain("random");
    endtask

    initial begin
        seed = 32'h219be9ba;
        checkCount = 0;
        errorCount = 0;
        failCount = 0;
        aborted = 1'b0;
        for (int p = 0; p < 2; p++) begin
            accepting[p] = 1'b0;
            pending[p] = 1'b0;
            waitCycles[p] = 0;
            lastLatency[p] = 0;
            acceptCount[p] = 0;
            doneCount[p] = 0;
        end
        rst = 1'b1;
        drivePort(ICache, 1'b0, 1'b0, '0, '0);
        drivePort(DCache, 1'b0, 1'b0, '0, '0);
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        checkBit("reset icBusy", 1'b0, icBusy);
        checkBit("reset dcBusy", 1'b0, dcBusy);
        checkBit("reset icDone", 1'b0, icDone);
        checkBit("reset dcDone", 1'b0, dcDone);

        singleAccessTest(ICache);
        if (!aborted) singleAccessTest(DCache);
        if (!aborted) priorityTest();
        if (!aborted) backPressureTest();
        if (!aborted) randomTrafficTest();
        if (!aborted) begin
            // each accepted request must have produced exactly one done.
            checkCycles("ic done per accept", acceptCount[ICache], doneCount[ICache]);
            checkCycles("dc done per accept", acceptCount[DCache], doneCount[DCache]);
        end

        $display("checks: %0d, value errors: %0d, other failures: %0d",
                 checkCount, errorCount, failCount);
        if (errorCount == 0 && failCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
